//--- logic/nocPkg.sv
package nocPkg;

  // ========================================
  // Router ports
  // ========================================
  localparam int numPorts = 5;
  localparam int portIdxW = 3;

  localparam logic [portIdxW-1:0] portL = 3'd0;
  localparam logic [portIdxW-1:0] portN = 3'd1;
  localparam logic [portIdxW-1:0] portE = 3'd2;
  localparam logic [portIdxW-1:0] portW = 3'd3;
  localparam logic [portIdxW-1:0] portS = 3'd4;

  // ========================================
  // Flit format
  // ========================================
  localparam int flitIdW  = 3;
  localparam int payloadW = 16;
  localparam int lengthW  = 12;  // Low bits of a head flit payload

  localparam logic [flitIdW-1:0] flitHead = 3'b001;
  localparam logic [flitIdW-1:0] flitBody = 3'b010;
  localparam logic [flitIdW-1:0] flitTail = 3'b100;

  // Input queues
  localparam int fifoDepth = 8;
  localparam int fifoPtrW  = $clog2(fifoDepth);
  localparam int fifoCntW  = $clog2(fifoDepth + 1);

  // One-hot arbiter states, bit 0 is idle, bit p+1 grants port p
  localparam int stateW = numPorts + 1;

  localparam logic [stateW-1:0] stIdle = 6'b000001;
  localparam logic [stateW-1:0] stL    = 6'b000010;
  localparam logic [stateW-1:0] stN    = 6'b000100;
  localparam logic [stateW-1:0] stE    = 6'b001000;
  localparam logic [stateW-1:0] stW    = 6'b010000;
  localparam logic [stateW-1:0] stS    = 6'b100000;

endpackage

//--- logic/flitFifo.sv
`timescale 1ns/1ps

module flitFifo (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wrEn,
  input  logic [nocPkg::flitIdW-1:0]  wrFlitId,
  input  logic [nocPkg::payloadW-1:0] wrPayload,
  input  logic                        pop,
  output logic [nocPkg::flitIdW-1:0]  headFlitId,
  output logic [nocPkg::payloadW-1:0] headPayload,
  output logic                        empty,
  output logic                        full
);

  import nocPkg::*;

  logic [flitIdW-1:0]  memFlitId  [fifoDepth];
  logic [payloadW-1:0] memPayload [fifoDepth];

  logic [fifoPtrW-1:0] rdPtr;
  logic [fifoPtrW-1:0] wrPtr;
  logic [fifoCntW-1:0] count;

  logic doPush;
  logic doPop;

  assign doPush = wrEn && !full;  // Write while full is dropped
  assign doPop  = pop && !empty;

  // ========================================
  // Storage
  // ========================================
  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      memFlitId[wrPtr]  <= wrFlitId;
      memPayload[wrPtr] <= wrPayload;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= (wrPtr == fifoPtrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == fifoPtrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;

      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is visible without a read cycle
  assign headFlitId  = memFlitId[rdPtr];
  assign headPayload = memPayload[rdPtr];

  assign empty = (count == '0);
  assign full  = (count == fifoCntW'(fifoDepth));

endmodule

//--- logic/holdTimer.sv
`timescale 1ns/1ps

module holdTimer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::flitIdW-1:0]  headFlitId,
  input  logic [nocPkg::payloadW-1:0] headPayload,
  input  logic                        runTimer,
  output logic                        timesUp
);

  import nocPkg::*;

  logic [lengthW-1:0] holdLen;  // Budget from the last head flit seen
  logic [lengthW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
      count   <= '0;
    end
    else
    begin
      if (headFlitId == flitHead)
        holdLen <= headPayload[lengthW-1:0];

      // Counts only while the port keeps its grant
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == holdLen);

endmodule

//--- logic/portArbiter.sv
`timescale 1ns/1ps

module portArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] reqs,
  input  logic [nocPkg::flitIdW-1:0]  headFlitId  [nocPkg::numPorts],
  input  logic [nocPkg::payloadW-1:0] headPayload [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] pop,
  output logic [nocPkg::portIdxW-1:0] grantPort
);

  import nocPkg::*;

  logic [stateW-1:0]   state;
  logic [stateW-1:0]   nextState;
  logic [numPorts-1:0] granted;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0] runTimer;

  // First requester after port last, wrapping back to last itself
  function automatic logic [stateW-1:0] pickAfter(
    input logic [numPorts-1:0] r,
    input logic [portIdxW-1:0] last
  );
    logic [stateW-1:0] pick;
    int                idx;
    pick = stIdle;
    // Walk backwards so the nearest requester is the one kept
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = (int'(last) + k) % numPorts;
      if (r[idx])
        pick = stateW'(1) << (idx + 1);
    end
    return pick;
  endfunction

  // ========================================
  // Hold timers
  // ========================================
  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    holdTimer timer (
      .clk         (clk),
      .rst         (rst),
      .headFlitId  (reqs[p] ? headFlitId[p] : '0),  // Empty queue has no head flit
      .headPayload (headPayload[p]),
      .runTimer    (runTimer[p]),
      .timesUp     (timesUp[p])
    );
  end

  assign granted = state[stateW-1:1];

  // Port stays while it requests and its budget remains
  assign runTimer = granted & reqs & ~timesUp;

  // ========================================
  // State machine
  // ========================================
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      stIdle:
        nextState = pickAfter(reqs, portS);  // Scan starts at L
      stL:
        nextState = runTimer[portL] ? stL : pickAfter(reqs, portL);
      stN:
        nextState = runTimer[portN] ? stN : pickAfter(reqs, portN);
      stE:
        nextState = runTimer[portE] ? stE : pickAfter(reqs, portE);
      stW:
        nextState = runTimer[portW] ? stW : pickAfter(reqs, portW);
      stS:
        nextState = runTimer[portS] ? stS : pickAfter(reqs, portS);
      default:
        nextState = stIdle;
    endcase
  end

  // Granted and non-empty ports pop every cycle
  assign pop = granted & reqs;

  always_comb
  begin
    grantPort = portL;
    for (int p = 0; p < numPorts; p++)
    begin
      if (granted[p])
        grantPort = portIdxW'(p);
    end
  end

endmodule

//--- logic/linkOutput.sv
`timescale 1ns/1ps

module linkOutput (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        popAny,
  input  logic [nocPkg::flitIdW-1:0]  selFlitId,
  input  logic [nocPkg::payloadW-1:0] selPayload,
  input  logic [nocPkg::portIdxW-1:0] grantPort,
  output logic                        outValid,
  output logic [nocPkg::flitIdW-1:0]  outFlitId,
  output logic [nocPkg::payloadW-1:0] outPayload,
  output logic [nocPkg::portIdxW-1:0] outPort
);

  // ========================================
  // Link strobe
  // ========================================
  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= popAny;  // One pulse per popped flit
  end

  // Flit fields are only meaningful with outValid
  always_ff @(posedge clk)
  begin
    if (popAny)
    begin
      outFlitId  <= selFlitId;
      outPayload <= selPayload;
      outPort    <= grantPort;
    end
  end

endmodule

//--- logic/routerOutputStage.sv
`timescale 1ns/1ps

module routerOutputStage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  logic [nocPkg::flitIdW-1:0]  inFlitId  [nocPkg::numPorts],
  input  logic [nocPkg::payloadW-1:0] inPayload [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inFull,
  output logic                        outValid,
  output logic [nocPkg::flitIdW-1:0]  outFlitId,
  output logic [nocPkg::payloadW-1:0] outPayload,
  output logic [nocPkg::portIdxW-1:0] outPort
);

  import nocPkg::*;

  logic [numPorts-1:0] empty;
  logic [numPorts-1:0] reqs;
  logic [numPorts-1:0] pop;
  logic [flitIdW-1:0]  headFlitId  [numPorts];
  logic [payloadW-1:0] headPayload [numPorts];
  logic [portIdxW-1:0] grantPort;
  logic [flitIdW-1:0]  selFlitId;
  logic [payloadW-1:0] selPayload;

  // ========================================
  // Input queues
  // ========================================
  for (genvar p = 0; p < numPorts; p++)
  begin : genFifo
    flitFifo fifo (
      .clk         (clk),
      .rst         (rst),
      .wrEn        (inValid[p]),
      .wrFlitId    (inFlitId[p]),
      .wrPayload   (inPayload[p]),
      .pop         (pop[p]),
      .headFlitId  (headFlitId[p]),
      .headPayload (headPayload[p]),
      .empty       (empty[p]),
      .full        (inFull[p])
    );
  end

  assign reqs = ~empty;

  portArbiter arbiter (
    .clk         (clk),
    .rst         (rst),
    .reqs        (reqs),
    .headFlitId  (headFlitId),
    .headPayload (headPayload),
    .pop         (pop),
    .grantPort   (grantPort)
  );

  // Head of the granted queue
  assign selFlitId  = headFlitId[grantPort];
  assign selPayload = headPayload[grantPort];

  linkOutput link (
    .clk        (clk),
    .rst        (rst),
    .popAny     (|pop),
    .selFlitId  (selFlitId),
    .selPayload (selPayload),
    .grantPort  (grantPort),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outPayload (outPayload),
    .outPort    (outPort)
  );

endmodule

//--- testbench/routerTb.sv
`timescale 1ns/1ps

module routerTb;

  import nocPkg::*;

  localparam int flitW     = flitIdW + payloadW;
  localparam int rstCycles = 10;

  logic                clk = 1'b0;
  logic                rst;
  logic [numPorts-1:0] inValid;
  logic [flitIdW-1:0]  inFlitId  [numPorts];
  logic [payloadW-1:0] inPayload [numPorts];
  logic [numPorts-1:0] inFull;
  logic                outValid;
  logic [flitIdW-1:0]  outFlitId;
  logic [payloadW-1:0] outPayload;
  logic [portIdxW-1:0] outPort;

  int errors     = 0;
  int timeouts   = 0;
  int fullCycles = 0;
  int singlePort = -1;  // Only port allowed on the link, -1 for any
  int lastPort   = -1;
  int sinceRst   = 0;
  int pktLeft [numPorts];

  // ========================================
  // Reference model
  // ========================================
  // Per-port queue contents, used to find each FIFO head
  logic [flitW-1:0]   qMem [numPorts][fifoDepth];
  int                 qRd  [numPorts];
  int                 qWr  [numPorts];
  int                 qCnt [numPorts];
  logic [lengthW-1:0] mLen [numPorts];
  logic [lengthW-1:0] mCnt [numPorts];
  int                 mState    = -1;  // Granted port, -1 when idle
  logic               predValid = 1'b0;
  int                 predPort  = 0;
  logic [flitW-1:0]   expQ [numPorts][$];  // Accepted flits still owed to the link

  routerOutputStage DUT (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inFlitId   (inFlitId),
    .inPayload  (inPayload),
    .inFull     (inFull),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outPayload (outPayload),
    .outPort    (outPort)
  );

  initial
  begin
    forever #20 clk = ~clk;
  end

  task automatic reportMismatch(input string sig, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    errors++;
    $display("FAIL %s expected %h got %h", sig, expVal, gotVal);
  endtask

  task automatic reportProblem(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  // Nearest requester after port from, ending with from itself
  function automatic int firstAfter(input logic [numPorts-1:0] r, input int from);
    int idx;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (from + k) % numPorts;
      if (r[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic logic allDrained();
    for (int p = 0; p < numPorts; p++)
    begin
      if (expQ[p].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // Checks use the state after the last edge, then the model steps to the next one
  always @(negedge clk)
  begin
    int                  op;
    logic [flitW-1:0]    expFlit;
    logic [numPorts-1:0] req;
    logic [numPorts-1:0] accept;
    logic                stay;
    int                  nextSt;
    logic [flitW-1:0]    head;

    // ========================================
    // Checks
    // ========================================
    if (sinceRst <= 1)
    begin
      assert (!outValid) else reportMismatch("outValid in reset", 0, 32'(outValid));
      assert (inFull == '0) else reportMismatch("inFull in reset", 0, 32'(inFull));
    end

    for (int p = 0; p < numPorts; p++)
    begin
      assert (inFull[p] == (qCnt[p] == fifoDepth))
      else reportMismatch($sformatf("inFull[%0d]", p), 32'(qCnt[p] == fifoDepth), 32'(inFull[p]));
      if (inFull[p])
        fullCycles++;
    end

    assert (outValid == predValid) else reportMismatch("outValid", 32'(predValid), 32'(outValid));

    if (outValid && predValid)
    begin
      op = int'(outPort);
      if (singlePort >= 0)
      begin
        assert (op == singlePort) else reportMismatch("outPort", 32'(singlePort), 32'(outPort));
      end
      if (op != lastPort)
      begin
        // New run must come from the rotation
        assert (op == predPort) else reportMismatch("outPort rotation", 32'(predPort), 32'(outPort));
      end
      else
      begin
        assert (op == predPort) else reportMismatch("outPort hold", 32'(predPort), 32'(outPort));
      end

      if (op >= numPorts)
        reportProblem($sformatf("flit delivered from port %0d which does not exist", op));
      else if (expQ[op].size() == 0)
        reportProblem($sformatf("flit delivered from port %0d with nothing queued", op));
      else
      begin
        expFlit = expQ[op].pop_front();
        assert (outFlitId == expFlit[flitW-1 -: flitIdW])
        else reportMismatch("outFlitId", 32'(expFlit[flitW-1 -: flitIdW]), 32'(outFlitId));
        assert (outPayload == expFlit[payloadW-1:0])
        else reportMismatch("outPayload", 32'(expFlit[payloadW-1:0]), 32'(outPayload));
      end
      lastPort = op;
    end

    // ========================================
    // Model step for the coming edge
    // ========================================
    sinceRst  = rst ? 0 : sinceRst + 1;
    predValid = 1'b0;
    if (rst)
    begin
      mState = -1;
      for (int p = 0; p < numPorts; p++)
      begin
        qRd[p]  = 0;
        qWr[p]  = 0;
        qCnt[p] = 0;
        mLen[p] = '0;
        mCnt[p] = '0;
      end
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        req[p]    = (qCnt[p] != 0);
        accept[p] = inValid[p] && (qCnt[p] != fifoDepth);  // Full drops the write
      end

      stay = 1'b0;
      if (mState < 0)
        nextSt = firstAfter(req, numPorts - 1);
      else
      begin
        stay      = req[mState] && (mCnt[mState] != mLen[mState]);
        nextSt    = stay ? mState : firstAfter(req, mState);
        predValid = req[mState];
        predPort  = mState;
      end

      for (int p = 0; p < numPorts; p++)
      begin
        head = qMem[p][qRd[p]];
        if (qCnt[p] != 0 && head[flitW-1 -: flitIdW] == flitHead)
          mLen[p] = head[lengthW-1:0];
        if (stay && p == mState)
          mCnt[p] = mCnt[p] + 1'b1;
        else
          mCnt[p] = '0;
      end

      if (predValid)
      begin
        qRd[predPort] = (qRd[predPort] + 1) % fifoDepth;
        qCnt[predPort]--;
      end

      for (int p = 0; p < numPorts; p++)
      begin
        if (accept[p])
        begin
          qMem[p][qWr[p]] = {inFlitId[p], inPayload[p]};
          qWr[p]          = (qWr[p] + 1) % fifoDepth;
          qCnt[p]++;
          expQ[p].push_back({inFlitId[p], inPayload[p]});
        end
      end
      mState = nextSt;
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  // Packet is a head carrying its body count, the bodies, then a tail
  task automatic nextFlit(input int p);
    logic [payloadW-1:0] pay;
    int                  len;
    pay = payloadW'($urandom);
    if (pktLeft[p] == 0)
    begin
      len          = int'($urandom % 7);
      inFlitId[p]  = flitHead;
      inPayload[p] = {pay[payloadW-1:lengthW], lengthW'(len)};
      pktLeft[p]   = len + 1;
    end
    else
    begin
      inFlitId[p]  = (pktLeft[p] == 1) ? flitTail : flitBody;
      inPayload[p] = pay;
      pktLeft[p]--;
    end
  endtask

  task automatic runTraffic(input logic [numPorts-1:0] active, input int cycles,
                            input int rate);
    repeat (cycles)
    begin
      @(posedge clk);
      #2;
      for (int p = 0; p < numPorts; p++)
      begin
        inValid[p] = 1'b0;
        if (active[p] && !inFull[p] && int'($urandom % 100) < rate)
        begin
          nextFlit(p);
          inValid[p] = 1'b1;
        end
      end
    end
    @(posedge clk);
    #2;
    inValid = '0;
  endtask

  task automatic waitDrained(input int limit);
    int waited;
    waited = 0;
    while (!allDrained() && waited < limit)
    begin
      @(posedge clk);
      waited++;
    end
    if (!allDrained())
    begin
      timeouts++;
      $display("Timeout: flits still owed to the link after %0d cycles", limit);
    end
  endtask

  initial
  begin
    void'($urandom(32'h2c0d));
    rst     = 1'b1;
    inValid = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlitId[p]  = '0;
      inPayload[p] = '0;
      pktLeft[p]   = 0;
    end
    repeat (rstCycles) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (3) @(posedge clk);

    // Port N alone
    singlePort = int'(portN);
    runTraffic(5'b00010, 150, 60);
    waitDrained(300);
    singlePort = -1;

    runTraffic('1, 600, 90);  // Heavy load fills the queues
    runTraffic(5'b10101, 200, 70);
    runTraffic('1, 300, 35);
    waitDrained(600);

    $display("Run done: %0d errors, %0d timeouts, %0d full port cycles",
             errors, timeouts, fullCycles);
    if (errors == 0 && timeouts == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- files.f
logic/nocPkg.sv
logic/flitFifo.sv
logic/holdTimer.sv
logic/portArbiter.sv
logic/linkOutput.sv
logic/routerOutputStage.sv
testbench/routerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the router testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module routerTb -f files.f -o routerSim

./obj_dir/routerSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
